//--- verilog/oramCryptPkg.sv
/*
 * Shared widths, bucket geometry, cipher constant and payload types
 * for the ORAM encryption layer
 */
package oramCryptPkg;

    // Widths
    localparam int DataWidth      = 64;
    localparam int BlockWidth     = 32;
    localparam int BlocksPerBurst = 2;
    localparam int IvWidth        = 16;

    // Geometry in bursts
    localparam int BucketBursts = 4;
    localparam int PathBursts   = 12;

    // Pad pipeline depth
    localparam int PadLatency = 3;

    localparam logic [31:0] RoundConst = 32'h9e3779b9;

    typedef logic [DataWidth-1:0]  dataT;
    typedef logic [IvWidth-1:0]    ivT;
    typedef logic [BlockWidth-1:0] blockT;

    // Burst as it waits for its pad
    typedef struct packed {
        dataT data;
        logic isHeader;
        // Set on a path read
        logic toBackend;
    } burstT;

endpackage

//--- verilog/burstFifo.sv
/*
 * Synchronous circular-buffer FIFO with a type-parameterised payload
 * and a free-slot count
 */
`timescale 1ns/10ps

module burstFifo #(
    parameter int  FifoDepth = 8,
    parameter type payloadT  = oramCryptPkg::dataT
) (
    input  logic                           Clock,
    input  logic                           arstN,
    input  logic                           push,
    input  payloadT                        pushData,
    input  logic                           pop,
    output payloadT                        popData,
    output logic                           full,
    output logic                           empty,
    output logic [$clog2(FifoDepth+1)-1:0] freeSlots
);

    localparam int PtrWidth   = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
    localparam int CountWidth = $clog2(FifoDepth + 1);

    payloadT               mem [FifoDepth];
    logic [PtrWidth-1:0]   rdPtr;
    logic [PtrWidth-1:0]   wrPtr;
    logic [CountWidth-1:0] count;
    logic                  doPush;
    logic                  doPop;

    // Wrap explicitly so any depth works
    function automatic logic [PtrWidth-1:0] nextPtr(logic [PtrWidth-1:0] ptr);
        return (ptr == PtrWidth'(FifoDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign doPush = push & ~full;
    assign doPop  = pop & ~empty;

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) wrPtr <= nextPtr(wrPtr);
            if (doPop) rdPtr <= nextPtr(rdPtr);
            if (doPush && !doPop) count <= count + 1'b1;
            else if (doPop && !doPush) count <= count - 1'b1;
        end
    end

    always_ff @(posedge Clock) begin
        if (doPush) mem[wrPtr] <= pushData;
    end

    assign popData   = mem[rdPtr];
    assign full      = (count == CountWidth'(FifoDepth));
    assign empty     = (count == '0);
    assign freeSlots = CountWidth'(FifoDepth) - count;

endmodule

//--- verilog/bucketIngress.sv
/*
 * Ingress stage: start-up, path direction, input acceptance,
 * bucket position tracking and keystream counter issue
 */
`timescale 1ns/10ps

module bucketIngress #(
    parameter int FifoDepth = 8
) (
    input  logic                           Clock,
    input  logic                           arstN,
    input  logic                           dramInitDone,
    input  oramCryptPkg::dataT             dramReadData,
    input  logic                           dramReadValid,
    output logic                           dramReadReady,
    input  oramCryptPkg::dataT             backendWriteData,
    input  logic                           backendWriteValid,
    output logic                           backendWriteReady,
    input  logic                           dataFull,
    input  logic [$clog2(FifoDepth+1)-1:0] padFree,
    output logic                           dataPush,
    output oramCryptPkg::burstT            dataIn,
    output logic                           ctrValid,
    output oramCryptPkg::ivT               ctr
);

    localparam int BucketPosWidth = $clog2(oramCryptPkg::BucketBursts);
    localparam int PathPosWidth   = $clog2(oramCryptPkg::PathBursts);

    logic                      started;
    // High during a path read
    logic                      dirRead;
    logic [BucketPosWidth-1:0] bucketPos;
    logic [PathPosWidth-1:0]   pathPos;
    oramCryptPkg::ivT          ivReg;

    oramCryptPkg::dataT        selData;
    oramCryptPkg::ivT          curIv;
    logic                      selValid;
    logic                      selReady;
    logic                      spaceOk;
    logic                      isHeader;
    logic                      accept;

    // --------------------
    // Acceptance

    // Pad FIFO must also hold every pad still in the pipeline
    assign spaceOk  = ~dataFull & (padFree > oramCryptPkg::PadLatency);
    assign selReady = started & spaceOk;

    assign dramReadReady     = selReady & dirRead;
    assign backendWriteReady = selReady & ~dirRead;

    assign selData  = dirRead ? dramReadData : backendWriteData;
    assign selValid = dirRead ? dramReadValid : backendWriteValid;
    assign accept   = selValid & selReady;

    // --------------------
    // Tagging and counter

    assign isHeader = (bucketPos == '0);
    // Header carries a fresh IV, the rest of the bucket reuses it
    assign curIv    = isHeader ? selData[oramCryptPkg::IvWidth-1:0] : ivReg;

    assign ctr = curIv + oramCryptPkg::ivT'(bucketPos)
                 * oramCryptPkg::ivT'(oramCryptPkg::BlocksPerBurst);
    assign ctrValid = accept;

    assign dataPush          = accept;
    assign dataIn.data       = selData;
    assign dataIn.isHeader   = isHeader;
    assign dataIn.toBackend  = dirRead;

    // --------------------
    // State

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            started   <= 1'b0;
            dirRead   <= 1'b1;
            bucketPos <= '0;
            pathPos   <= '0;
            ivReg     <= '0;
        end else begin
            if (dramInitDone) started <= 1'b1;
            if (accept) begin
                if (isHeader) ivReg <= curIv;
                if (bucketPos == BucketPosWidth'(oramCryptPkg::BucketBursts - 1))
                    bucketPos <= '0;
                else
                    bucketPos <= bucketPos + 1'b1;
                // Last burst of a path turns the direction around
                if (pathPos == PathPosWidth'(oramCryptPkg::PathBursts - 1)) begin
                    pathPos <= '0;
                    dirRead <= ~dirRead;
                end else begin
                    pathPos <= pathPos + 1'b1;
                end
            end
        end
    end

endmodule

//--- verilog/padGenerator.sv
/*
 * Keystream pad generator: pipelined keyed mixing cipher,
 * one round per stage, one pad per burst
 */
`timescale 1ns/10ps

module padGenerator #(
    parameter oramCryptPkg::blockT Key = '1
) (
    input  logic               Clock,
    input  logic               arstN,
    input  logic               ctrValid,
    input  oramCryptPkg::ivT   ctr,
    output logic               padValid,
    output oramCryptPkg::dataT pad
);

    localparam int Stages = oramCryptPkg::PadLatency;
    localparam int Lanes  = oramCryptPkg::BlocksPerBurst;
    localparam int BW     = oramCryptPkg::BlockWidth;

    oramCryptPkg::blockT laneIn [Lanes];
    oramCryptPkg::blockT laneReg [Stages][Lanes];
    logic [Stages-1:0]   validReg;

    // Rotate left by 5, add constant, fold in key
    function automatic oramCryptPkg::blockT mixRound(oramCryptPkg::blockT x);
        oramCryptPkg::blockT rot;
        rot = {x[BW-6:0], x[BW-1:BW-5]};
        return (rot + oramCryptPkg::RoundConst) ^ Key;
    endfunction

    // Whitening of each block counter
    always_comb begin
        for (int j = 0; j < Lanes; j++) begin
            laneIn[j] = oramCryptPkg::blockT'(oramCryptPkg::ivT'(ctr + oramCryptPkg::ivT'(j)))
                        ^ Key;
        end
    end

    always_ff @(posedge Clock) begin
        for (int j = 0; j < Lanes; j++) begin
            laneReg[0][j] <= mixRound(laneIn[j]);
            for (int s = 1; s < Stages; s++) begin
                laneReg[s][j] <= mixRound(laneReg[s-1][j]);
            end
        end
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN)
            validReg <= '0;
        else
            validReg <= {validReg[Stages-2:0], ctrValid};
    end

    assign padValid = validReg[Stages-1];

    always_comb begin
        for (int j = 0; j < Lanes; j++) begin
            pad[j*BW +: BW] = laneReg[Stages-1][j];
        end
    end

endmodule

//--- verilog/bucketEgress.sv
/*
 * Egress stage: burst XOR pad, header IV restore,
 * routing to backend or DRAM and FIFO pop
 */
`timescale 1ns/10ps

module bucketEgress (
    input  oramCryptPkg::burstT burstHead,
    input  oramCryptPkg::dataT  padHead,
    input  logic                dataEmpty,
    input  logic                padEmpty,
    input  logic                backendReadReady,
    input  logic                dramWriteReady,
    output logic                popBoth,
    output oramCryptPkg::dataT  backendReadData,
    output logic                backendReadValid,
    output oramCryptPkg::dataT  dramWriteData,
    output logic                dramWriteValid
);

    localparam int DW = oramCryptPkg::DataWidth;
    localparam int IW = oramCryptPkg::IvWidth;

    oramCryptPkg::dataT mixed;
    oramCryptPkg::dataT outData;
    logic               headValid;
    logic               backendFire;
    logic               dramFire;

    // Burst and its pad leave together
    assign headValid = ~dataEmpty & ~padEmpty;

    // --------------------
    // Data path

    assign mixed = burstHead.data ^ padHead;

    // IV field of a header stays in plaintext
    assign outData = burstHead.isHeader ? {mixed[DW-1:IW], burstHead.data[IW-1:0]}
                                        : mixed;

    // --------------------
    // Routing

    assign backendReadData  = outData;
    assign dramWriteData    = outData;
    assign backendReadValid = headValid & burstHead.toBackend;
    assign dramWriteValid   = headValid & ~burstHead.toBackend;

    assign backendFire = backendReadValid & backendReadReady;
    assign dramFire    = dramWriteValid & dramWriteReady;

    assign popBoth = backendFire | dramFire;

endmodule

//--- verilog/oramCryptLayer.sv
/*
 * Top of the ORAM encryption layer: ingress, pad generator,
 * data and pad FIFOs, egress
 */
`timescale 1ns/10ps

module oramCryptLayer #(
    parameter oramCryptPkg::blockT Key       = 32'h5a3c96e1,
    parameter int                  FifoDepth = 8
) (
    input  logic               Clock,
    input  logic               arstN,
    input  logic               dramInitDone,
    input  oramCryptPkg::dataT dramReadData,
    input  logic               dramReadValid,
    output logic               dramReadReady,
    output oramCryptPkg::dataT dramWriteData,
    output logic               dramWriteValid,
    input  logic               dramWriteReady,
    output oramCryptPkg::dataT backendReadData,
    output logic               backendReadValid,
    input  logic               backendReadReady,
    input  oramCryptPkg::dataT backendWriteData,
    input  logic               backendWriteValid,
    output logic               backendWriteReady
);

    localparam int CountWidth = $clog2(FifoDepth + 1);

    logic                  dataPush;
    oramCryptPkg::burstT   dataIn;
    oramCryptPkg::burstT   dataHead;
    logic                  dataFull;
    logic                  dataEmpty;
    logic                  ctrValid;
    oramCryptPkg::ivT      ctr;
    logic                  padValid;
    oramCryptPkg::dataT    pad;
    oramCryptPkg::dataT    padHead;
    logic                  padEmpty;
    logic [CountWidth-1:0] padFree;
    logic                  popBoth;

    bucketIngress #(.FifoDepth(FifoDepth)) i_bucketIngress (
        .Clock(Clock), .arstN(arstN), .dramInitDone(dramInitDone),
        .dramReadData(dramReadData), .dramReadValid(dramReadValid),
        .dramReadReady(dramReadReady),
        .backendWriteData(backendWriteData), .backendWriteValid(backendWriteValid),
        .backendWriteReady(backendWriteReady),
        .dataFull(dataFull), .padFree(padFree),
        .dataPush(dataPush), .dataIn(dataIn), .ctrValid(ctrValid), .ctr(ctr)
    );

    padGenerator #(.Key(Key)) i_padGenerator (
        .Clock(Clock), .arstN(arstN), .ctrValid(ctrValid), .ctr(ctr),
        .padValid(padValid), .pad(pad)
    );

    // Bursts wait here while their pads are computed
    burstFifo #(.FifoDepth(FifoDepth), .payloadT(oramCryptPkg::burstT)) dataFifo (
        .Clock(Clock), .arstN(arstN), .push(dataPush), .pushData(dataIn),
        .pop(popBoth), .popData(dataHead), .full(dataFull), .empty(dataEmpty),
        .freeSlots()
    );

    burstFifo #(.FifoDepth(FifoDepth), .payloadT(oramCryptPkg::dataT)) padFifo (
        .Clock(Clock), .arstN(arstN), .push(padValid), .pushData(pad),
        .pop(popBoth), .popData(padHead), .full(), .empty(padEmpty),
        .freeSlots(padFree)
    );

    bucketEgress i_bucketEgress (
        .burstHead(dataHead), .padHead(padHead),
        .dataEmpty(dataEmpty), .padEmpty(padEmpty),
        .backendReadReady(backendReadReady), .dramWriteReady(dramWriteReady),
        .popBoth(popBoth),
        .backendReadData(backendReadData), .backendReadValid(backendReadValid),
        .dramWriteData(dramWriteData), .dramWriteValid(dramWriteValid)
    );

endmodule

//--- verification/oramCryptTb.sv
/*
 * Testbench for the ORAM encryption layer with clock, reset, path stimulus,
 * reference pad model, output compare and watchdog
 */
`timescale 1ns/10ps

module oramCryptTb;

    localparam logic [31:0] TbKey    = 32'h5a3c96e1;
    localparam logic [31:0] MixConst = 32'h9e3779b9;
    localparam int          Depth    = 8;
    localparam int          NumPaths = 5;
    localparam int          Bursts   = oramCryptPkg::PathBursts;
    localparam int          Bucket   = oramCryptPkg::BucketBursts;

    logic               Clock;
    logic               arstN;
    logic               dramInitDone;
    oramCryptPkg::dataT dramReadData;
    logic               dramReadValid;
    logic               dramReadReady;
    oramCryptPkg::dataT dramWriteData;
    logic               dramWriteValid;
    logic               dramWriteReady;
    oramCryptPkg::dataT backendReadData;
    logic               backendReadValid;
    logic               backendReadReady;
    oramCryptPkg::dataT backendWriteData;
    logic               backendWriteValid;
    logic               backendWriteReady;

    oramCryptPkg::dataT expBackend[$];
    oramCryptPkg::dataT expDram[$];
    // Ciphertext seen on the DRAM write port and replayed in the round trip
    oramCryptPkg::dataT dramSeen[$];
    int                 mismatchCount = 0;
    int                 otherErrors = 0;
    logic               stallOut = 1'b0;

    oramCryptLayer #(.Key(TbKey), .FifoDepth(Depth)) i_oramCryptLayer (.*);

    initial begin : clockGen
        Clock = 1'b0;
        forever #20 Clock = ~Clock;
    end

    // --------------------
    // Reference model

    function automatic logic [31:0] mixBlock(logic [15:0] c);
        logic [31:0] x;
        x = {16'h0000, c} ^ TbKey;
        for (int r = 0; r < 3; r++) begin
            x = {x[26:0], x[31:27]} + MixConst;
            x = x ^ TbKey;
        end
        return x;
    endfunction

    // Burst at position pos of a bucket whose header carried iv
    function automatic logic [63:0] cryptBurst(logic [63:0] data, logic [15:0] iv, int pos);
        logic [15:0] c;
        logic [63:0] result;
        c = iv + 16'(pos * 2);
        result = data ^ {mixBlock(c + 16'd1), mixBlock(c)};
        if (pos == 0)
            result[15:0] = data[15:0];
        return result;
    endfunction

    task automatic checkValue(input logic [63:0] got, input logic [63:0] want,
                              input string what);
        if (got !== want) begin
            $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, want);
            mismatchCount++;
        end
    endtask

    task automatic makeRandomPath(output oramCryptPkg::dataT words[$]);
        words = {};
        for (int k = 0; k < Bursts; k++)
            words.push_back({$urandom, $urandom});
    endtask

    // One path on the port of the given direction with random valid gaps
    task automatic sendPath(input bit readDir, input oramCryptPkg::dataT words[$],
                            input oramCryptPkg::dataT plain[$]);
        int          k;
        logic [15:0] iv;
        logic [63:0] want;
        k = 0;
        iv = '0;
        while (k < Bursts) begin
            @(posedge Clock);
            #2;
            if (readDir) begin
                dramReadData  = words[k];
                dramReadValid = ($urandom % 4) != 0;
            end else begin
                backendWriteData  = words[k];
                backendWriteValid = ($urandom % 4) != 0;
            end
            @(negedge Clock);
            checkValue(readDir ? backendWriteReady : dramReadReady, 0,
                       "ready of the inactive direction");
            if (readDir ? (dramReadValid && dramReadReady)
                        : (backendWriteValid && backendWriteReady)) begin
                if (k % Bucket == 0)
                    iv = words[k][15:0];
                want = (plain.size() > 0) ? plain[k] : cryptBurst(words[k], iv, k % Bucket);
                if (readDir)
                    expBackend.push_back(want);
                else
                    expDram.push_back(want);
                k++;
            end
        end
        @(posedge Clock);
        #2;
        dramReadValid     = 1'b0;
        backendWriteValid = 1'b0;
    endtask

    // --------------------
    // Output side

    initial begin : driveOutputReady
        forever begin
            @(posedge Clock);
            #2;
            backendReadReady = !stallOut && (($urandom % 4) != 0);
            dramWriteReady   = !stallOut && (($urandom % 4) != 0);
        end
    end

    initial begin : compareOutputs
        forever begin
            @(negedge Clock);
            if (arstN && backendReadValid && backendReadReady) begin
                if (expBackend.size() == 0) begin
                    $display("Burst on the backend read port with none expected at %0t", $time);
                    otherErrors++;
                end else begin
                    checkValue(backendReadData, expBackend.pop_front(), "backend read data");
                end
            end
            if (arstN && dramWriteValid && dramWriteReady) begin
                dramSeen.push_back(dramWriteData);
                if (expDram.size() == 0) begin
                    $display("Burst on the DRAM write port with none expected at %0t", $time);
                    otherErrors++;
                end else begin
                    checkValue(dramWriteData, expDram.pop_front(), "DRAM write data");
                end
            end
        end
    end

    initial begin : watchdog
        repeat (NumPaths * Bursts * 20 + 200) @(posedge Clock);
        $display("Timeout: outputs still pending after the time allowed for all paths");
        $display(">>> FAIL");
        $finish;
    end

    // --------------------
    // Main sequence

    initial begin : mainSequence
        oramCryptPkg::dataT words[$];
        oramCryptPkg::dataT plain[$];
        oramCryptPkg::dataT noPlain[$];
        void'($urandom(32'hf80ca673));
        arstN = 1'b0;
        dramInitDone = 1'b0;
        dramReadData = '0;
        dramReadValid = 1'b0;
        dramWriteReady = 1'b0;
        backendReadReady = 1'b0;
        backendWriteData = '0;
        backendWriteValid = 1'b0;
        noPlain = {};
        repeat (5) @(posedge Clock);
        #2;
        arstN = 1'b1;
        dramReadValid = 1'b1;

        // Nothing moves before DRAM init
        repeat (10) begin
            @(negedge Clock);
            checkValue({dramReadReady, backendWriteReady, backendReadValid, dramWriteValid},
                       0, "handshake before init");
        end
        @(posedge Clock);
        #2;
        dramReadValid = 1'b0;
        dramInitDone  = 1'b1;

        // Read path with outputs stalled until the FIFOs fill
        stallOut = 1'b1;
        makeRandomPath(words);
        fork
            sendPath(1'b1, words, noPlain);
            begin
                repeat (40) @(posedge Clock);
                @(negedge Clock);
                checkValue(dramReadReady, 0, "DRAM read ready with full FIFOs");
                if (expBackend.size() == 0 || expBackend.size() > Depth) begin
                    $display("Accepted %0d bursts while stalled, outside 1..%0d",
                             expBackend.size(), Depth);
                    otherErrors++;
                end
                stallOut = 1'b0;
            end
        join

        // Write path and then its ciphertext back as the next read path
        makeRandomPath(plain);
        dramSeen = {};
        sendPath(1'b0, plain, noPlain);
        while (dramSeen.size() < Bursts) @(posedge Clock);
        words = dramSeen;
        sendPath(1'b1, words, plain);

        makeRandomPath(words);
        sendPath(1'b0, words, noPlain);
        makeRandomPath(words);
        sendPath(1'b1, words, noPlain);

        while (expBackend.size() > 0 || expDram.size() > 0) @(posedge Clock);
        repeat (10) @(posedge Clock);
        $display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherErrors);
        if (mismatchCount == 0 && otherErrors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

//--- oramCryptLayer.f
verilog/oramCryptPkg.sv
verilog/burstFifo.sv
verilog/bucketIngress.sv
verilog/padGenerator.sv
verilog/bucketEgress.sv
verilog/oramCryptLayer.sv
verification/oramCryptTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the ORAM encryption layer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing -Wno-fatal --top-module oramCryptTb \
    -f oramCryptLayer.f -o oramCryptSim > build.log 2>&1 \
    && ./obj_dir/oramCryptSim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }

cat sim.log
grep -q ">>> FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "Simulation did not complete"; exit 1; }
exit 0
